// File: include/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// pc counts halfwords, bit 10 is above the tag and never compared
`define BP_PC_W 11

// table geometry, 4-way set associative, 64 entries
`define BP_SETS 16
`define BP_WAYS 4
`define BP_SET_W 4

// tag sits right above the set index in the pc
`define BP_TAG_W 6

// one-hot branch type vectors from decode
`define BP_BTYPE_W 6
`define BP_CBTYPE_W 2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch prediction testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_bp_top

verilator --binary --timing -Wno-fatal -f sim.f --top-module "$TOP" \
	--Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -Fxq "PASS: all tests" "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi

// File: sim.f
+incdir+include
src/bp_entry_pkg.sv
src/bp_branch_pkg.sv
src/bht_table.sv
src/branch_resolve.sv
src/flush_ctrl.sv
src/next_pc_select.sv
src/bp_top.sv
tests/tb_bp_top.sv

// File: src/bht_table.sv
`timescale 1ns/100ps
`include "bp_params.svh"

module bht_table (
	input logic CLK,
	input logic nrst,
	input logic en,
	// fetch lookup
	input logic [`BP_PC_W-1:0] if_pc,
	// decode lookup and allocation
	input logic [`BP_PC_W-1:0] id_pc,
	input logic [`BP_PC_W-1:0] id_branch_target,
	input logic id_is_jump,
	input logic id_is_btype,
	// execute lookup and training
	input logic [`BP_PC_W-1:0] exe_pc,
	input logic exe_branch,
	input logic exe_taken,
	output logic if_hit,
	output logic if_prediction,
	output logic [`BP_PC_W-1:0] if_pbt,
	output logic id_hit,
	output bp_entry_pkg::sat_ctr_t exe_counter,
	output logic [`BP_PC_W-1:0] exe_pbt
);

	// lookup port numbering
	localparam int LK_IF = 0;
	localparam int LK_ID = 1;
	localparam int LK_EXE = 2;
	localparam int LK_N = 3;

	// entry storage and one replacement pointer per set
	bp_entry_pkg::bht_entry_t bht_q [`BP_SETS][`BP_WAYS];
	bp_entry_pkg::way_idx_t fifo_q [`BP_SETS];

	bp_entry_pkg::set_idx_t lk_set [LK_N];
	bp_entry_pkg::tag_t lk_tag [LK_N];
	logic lk_hit [LK_N];
	bp_entry_pkg::way_idx_t lk_way [LK_N];
	bp_entry_pkg::bht_entry_t lk_entry [LK_N];

	logic alloc;
	logic train;
	bp_entry_pkg::bht_entry_t alloc_entry;
	bp_entry_pkg::sat_ctr_t train_ctr;

	////////////////////////////////////////////////////////////////////////////
	// lookups
	// set from pc[3:0], tag from pc[9:4]

	assign lk_set[LK_IF] = if_pc[`BP_SET_W-1:0];
	assign lk_tag[LK_IF] = if_pc[`BP_SET_W +: `BP_TAG_W];
	assign lk_set[LK_ID] = id_pc[`BP_SET_W-1:0];
	assign lk_tag[LK_ID] = id_pc[`BP_SET_W +: `BP_TAG_W];
	assign lk_set[LK_EXE] = exe_pc[`BP_SET_W-1:0];
	assign lk_tag[LK_EXE] = exe_pc[`BP_SET_W +: `BP_TAG_W];

	// same compare for every port over the four ways of its set
	always_comb begin
		for (int p = 0; p < LK_N; p++) begin
			lk_hit[p] = 1'b0;
			lk_way[p] = '0;
			// walk downwards so the lowest matching way wins
			for (int w = `BP_WAYS - 1; w >= 0; w--) begin
				if (bht_q[lk_set[p]][w].valid && bht_q[lk_set[p]][w].tag == lk_tag[p]) begin
					lk_hit[p] = 1'b1;
					lk_way[p] = bp_entry_pkg::way_idx_t'(w);
				end
			end
			// a miss looks like an empty line, not taken to address 0
			lk_entry[p] = lk_hit[p] ? bht_q[lk_set[p]][lk_way[p]] : '0;
		end
	end

	// fetch side
	assign if_hit = lk_hit[LK_IF];
	assign if_prediction = lk_entry[LK_IF].counter[1];
	assign if_pbt = lk_entry[LK_IF].target;

	// decode side
	assign id_hit = lk_hit[LK_ID];

	// execute side
	assign exe_counter = lk_entry[LK_EXE].counter;
	assign exe_pbt = lk_entry[LK_EXE].target;

	////////////////////////////////////////////////////////////////////////////
	// write side

	// new branch or jump seen in decode
	assign alloc = (id_is_btype || id_is_jump) && !lk_hit[LK_ID];
	// resolved branch already in the table
	assign train = exe_branch && lk_hit[LK_EXE];

	always_comb begin
		alloc_entry.valid = 1'b1;
		alloc_entry.tag = lk_tag[LK_ID];
		alloc_entry.target = id_branch_target;
		// jumps are always taken so they start saturated
		alloc_entry.counter = id_is_jump ? bp_entry_pkg::ctr_strong_t :
			bp_entry_pkg::ctr_weak_nt;
	end

	// step toward the real outcome, hold at both ends
	always_comb begin
		train_ctr = lk_entry[LK_EXE].counter;
		if (exe_taken && lk_entry[LK_EXE].counter != bp_entry_pkg::ctr_strong_t)
			train_ctr = lk_entry[LK_EXE].counter + 2'd1;
		else if (!exe_taken && lk_entry[LK_EXE].counter != bp_entry_pkg::ctr_strong_nt)
			train_ctr = lk_entry[LK_EXE].counter - 2'd1;
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				fifo_q[s] <= '0;
				for (int w = 0; w < `BP_WAYS; w++) begin
					bht_q[s][w].valid <= 1'b0;
				end
			end
		end else if (en) begin
			// decode allocation wins over execute training
			if (alloc) begin
				bht_q[lk_set[LK_ID]][fifo_q[lk_set[LK_ID]]] <= alloc_entry;
				// oldest way goes next, wraps 3 -> 0
				fifo_q[lk_set[LK_ID]] <= fifo_q[lk_set[LK_ID]] + 2'd1;
			end else if (train) begin
				bht_q[lk_set[LK_EXE]][lk_way[LK_EXE]].counter <= train_ctr;
			end
		end
	end

endmodule

// File: src/bp_branch_pkg.sv
`include "bp_params.svh"

package bp_branch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bit positions in the base branch type vector
	// beq sits in the msb, bgeu in the lsb

	typedef enum int unsigned {
		bt_bgeu = 0,
		bt_bltu = 1,
		bt_bge = 2,
		bt_blt = 3,
		bt_bne = 4,
		bt_beq = 5
	} btype_pos_e;

	// compressed branches compare against zero
	typedef enum int unsigned {
		cbt_bnez = 0,
		cbt_beqz = 1
	} c_btype_pos_e;

	////////////////////////////////////////////////////////////////////////////
	// correction codes out of EXE
	// msb set means the fetch stream must be redirected

	typedef enum logic [1:0] {
		corr_none = 2'b00,
		// predicted taken, really fell through
		corr_cni = 2'b10,
		// predicted not taken, really taken
		corr_pbt = 2'b11
	} corr_e;

	// where the next fetch address comes from
	typedef enum logic [2:0] {
		pc_src_seq,
		pc_src_if_pbt,
		pc_src_id_target,
		pc_src_exe_cni,
		pc_src_exe_pbt
	} pc_src_e;

	// one extra flush cycle is owed while in fl_hold
	typedef enum logic {
		fl_idle = 1'b0,
		fl_hold = 1'b1
	} flush_state_e;

	// sequential step, one 32-bit instruction in halfwords
	localparam logic [`BP_PC_W-1:0] pc_inc = {{(`BP_PC_W-2){1'b0}}, 2'd2};

endpackage

// File: src/bp_entry_pkg.sv
`include "bp_params.svh"

package bp_entry_pkg;

	////////////////////////////////////////////////////////////////////////////
	// table addressing

	typedef logic [`BP_SET_W-1:0] set_idx_t;
	typedef logic [$clog2(`BP_WAYS)-1:0] way_idx_t;
	typedef logic [`BP_TAG_W-1:0] tag_t;
	typedef logic [`BP_PC_W-1:0] pc_t;

	////////////////////////////////////////////////////////////////////////////
	// 2-bit saturating counter, bit 1 is the taken prediction

	typedef logic [1:0] sat_ctr_t;

	// floor and ceiling of the counter
	localparam sat_ctr_t ctr_strong_nt = 2'b00;
	localparam sat_ctr_t ctr_strong_t = 2'b11;
	// new branches start one step below taken
	localparam sat_ctr_t ctr_weak_nt = 2'b01;

	////////////////////////////////////////////////////////////////////////////
	// one table line, 20 bits
	// valid in the msb, counter in the two lsbs

	typedef struct packed {
		logic valid;
		tag_t tag;
		pc_t target;
		sat_ctr_t counter;
	} bht_entry_t;

endpackage

// File: src/bp_top.sv
`timescale 1ns/100ps
`include "bp_params.svh"

module bp_top (
	input logic CLK,
	input logic nrst,
	input logic en,
	// fetch
	input logic [`BP_PC_W-1:0] if_pc,
	// decode
	input logic [`BP_PC_W-1:0] id_pc,
	input logic [`BP_PC_W-1:0] id_branch_target,
	input logic id_is_jump,
	input logic id_is_btype,
	// execute
	input logic [`BP_PC_W-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input logic [`BP_BTYPE_W-1:0] exe_btype,
	input logic [`BP_CBTYPE_W-1:0] exe_c_btype,
	output logic if_prediction,
	output logic [1:0] exe_correction,
	output logic flush,
	output logic id_jump_in_bht,
	output logic [`BP_PC_W-1:0] next_pc
);

	////////////////////////////////////////////////////////////////////////////
	// internal nets

	logic [`BP_PC_W-1:0] if_pbt;
	logic id_hit;
	logic [1:0] exe_counter;
	logic [`BP_PC_W-1:0] exe_pbt;
	logic [`BP_PC_W-1:0] exe_cni;
	logic exe_branch;
	logic exe_taken;
	logic exe_mispredict;

	// if_hit left open, only useful on a waveform
	bht_table i_bht_table (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_pc(if_pc),
		.id_pc(id_pc),
		.id_branch_target(id_branch_target),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.exe_pc(exe_pc),
		.exe_branch(exe_branch),
		.exe_taken(exe_taken),
		.if_hit(),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.id_hit(id_hit),
		.exe_counter(exe_counter),
		.exe_pbt(exe_pbt)
	);

	branch_resolve i_branch_resolve (
		.exe_pc(exe_pc),
		.exe_z(exe_z),
		.exe_less(exe_less),
		.exe_btype(exe_btype),
		.exe_c_btype(exe_c_btype),
		.exe_counter(exe_counter),
		.exe_branch(exe_branch),
		.exe_taken(exe_taken),
		.exe_mispredict(exe_mispredict),
		.exe_correction(exe_correction),
		.exe_cni(exe_cni)
	);

	flush_ctrl i_flush_ctrl (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.exe_mispredict(exe_mispredict),
		.id_is_jump(id_is_jump),
		.id_hit(id_hit),
		.flush(flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	next_pc_select i_next_pc_select (
		.if_pc(if_pc),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.id_is_jump(id_is_jump),
		.id_hit(id_hit),
		.id_branch_target(id_branch_target),
		.exe_correction(exe_correction),
		.exe_cni(exe_cni),
		.exe_pbt(exe_pbt),
		.next_pc(next_pc)
	);

endmodule

// File: src/branch_resolve.sv
`timescale 1ns/100ps
`include "bp_params.svh"

module branch_resolve (
	input logic [`BP_PC_W-1:0] exe_pc,
	// alu flags
	input logic exe_z,
	input logic exe_less,
	// one-hot branch type
	input logic [`BP_BTYPE_W-1:0] exe_btype,
	input logic [`BP_CBTYPE_W-1:0] exe_c_btype,
	// counter read from the table in EXE
	input bp_entry_pkg::sat_ctr_t exe_counter,
	output logic exe_branch,
	output logic exe_taken,
	output logic exe_mispredict,
	output logic [1:0] exe_correction,
	output logic [`BP_PC_W-1:0] exe_cni
);

	// branch classes by the flag they test
	logic eq_type;
	logic ne_type;
	logic lt_type;
	logic ge_type;

	assign eq_type = exe_btype[bp_branch_pkg::bt_beq] | exe_c_btype[bp_branch_pkg::cbt_beqz];
	assign ne_type = exe_btype[bp_branch_pkg::bt_bne] | exe_c_btype[bp_branch_pkg::cbt_bnez];
	// signed and unsigned share the less flag
	assign lt_type = exe_btype[bp_branch_pkg::bt_blt] | exe_btype[bp_branch_pkg::bt_bltu];
	assign ge_type = exe_btype[bp_branch_pkg::bt_bge] | exe_btype[bp_branch_pkg::bt_bgeu];

	assign exe_branch = (|exe_btype) | (|exe_c_btype);

	// real outcome
	assign exe_taken = (eq_type & exe_z) | (ne_type & ~exe_z) |
		(lt_type & exe_less) | (ge_type & ~exe_less);

	// counter msb was the guess made at fetch
	assign exe_mispredict = exe_branch && (exe_taken != exe_counter[1]);

	always_comb begin
		if (!exe_mispredict)
			exe_correction = bp_branch_pkg::corr_none;
		else if (exe_taken)
			exe_correction = bp_branch_pkg::corr_pbt;
		else
			exe_correction = bp_branch_pkg::corr_cni;
	end

	// fall-through address of the branch
	assign exe_cni = exe_pc + bp_branch_pkg::pc_inc;

endmodule

// File: src/flush_ctrl.sv
`timescale 1ns/100ps

module flush_ctrl (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic exe_mispredict,
	input logic id_is_jump,
	input logic id_hit,
	output logic flush,
	output logic id_jump_in_bht
);

	bp_branch_pkg::flush_state_e state_q;
	bp_branch_pkg::flush_state_e state_d;

	////////////////////////////////////////////////////////////////////////////
	// flush level
	// a mispredict flushes now and once more, a jump miss flushes next cycle

	always_comb begin
		if (state_q == bp_branch_pkg::fl_hold) begin
			// owed cycle, nothing new is taken in
			flush = 1'b1;
			state_d = bp_branch_pkg::fl_idle;
		end else if (exe_mispredict) begin
			flush = 1'b1;
			state_d = bp_branch_pkg::fl_hold;
		end else begin
			flush = 1'b0;
			// jump target only known in ID, younger fetch is wrong
			state_d = (id_is_jump && !id_hit) ? bp_branch_pkg::fl_hold :
				bp_branch_pkg::fl_idle;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst)
			state_q <= bp_branch_pkg::fl_idle;
		else if (en)
			state_q <= state_d;
	end

	// jump already predicted taken at fetch
	assign id_jump_in_bht = id_is_jump && id_hit;

endmodule

// File: src/next_pc_select.sv
`timescale 1ns/100ps
`include "bp_params.svh"

module next_pc_select (
	input logic [`BP_PC_W-1:0] if_pc,
	input logic if_prediction,
	input logic [`BP_PC_W-1:0] if_pbt,
	input logic id_is_jump,
	input logic id_hit,
	input logic [`BP_PC_W-1:0] id_branch_target,
	input logic [1:0] exe_correction,
	input logic [`BP_PC_W-1:0] exe_cni,
	input logic [`BP_PC_W-1:0] exe_pbt,
	output logic [`BP_PC_W-1:0] next_pc
);

	bp_branch_pkg::pc_src_e pc_src;

	// oldest stage has the final word
	always_comb begin
		if (exe_correction == bp_branch_pkg::corr_pbt)
			pc_src = bp_branch_pkg::pc_src_exe_pbt;
		else if (exe_correction == bp_branch_pkg::corr_cni)
			pc_src = bp_branch_pkg::pc_src_exe_cni;
		else if (id_is_jump && !id_hit)
			pc_src = bp_branch_pkg::pc_src_id_target;
		else if (if_prediction)
			pc_src = bp_branch_pkg::pc_src_if_pbt;
		else
			pc_src = bp_branch_pkg::pc_src_seq;
	end

	always_comb begin
		case (pc_src)
			bp_branch_pkg::pc_src_exe_pbt: next_pc = exe_pbt;
			bp_branch_pkg::pc_src_exe_cni: next_pc = exe_cni;
			bp_branch_pkg::pc_src_id_target: next_pc = id_branch_target;
			bp_branch_pkg::pc_src_if_pbt: next_pc = if_pbt;
			default: next_pc = if_pc + bp_branch_pkg::pc_inc;
		endcase
	end

endmodule

// File: tests/tb_bp_top.sv
`timescale 1ns/100ps
`include "bp_params.svh"

module tb_bp_top;

	// one row of the stimulus table
	typedef struct packed {
		// en, id_is_jump, id_is_btype
		logic [2:0] ctl;
		logic [`BP_PC_W-1:0] if_pc;
		logic [`BP_PC_W-1:0] id_pc;
		logic [`BP_PC_W-1:0] id_tgt;
		logic [`BP_PC_W-1:0] exe_pc;
		// exe_z, exe_less
		logic [1:0] flags;
		logic [`BP_BTYPE_W-1:0] btype;
		logic [`BP_CBTYPE_W-1:0] cbtype;
		// if_prediction, flush, id_jump_in_bht
		logic [2:0] exp_bits;
		logic [1:0] exp_corr;
		logic [`BP_PC_W-1:0] exp_next;
	} step_t;

	localparam int reset_cycles = 10;
	// slack beyond the table length before the run is cut off
	localparam int timeout_slack = 20;
	// seed for randomized rows, none in the table yet
	localparam int rand_seed = 61;

	logic CLK;
	logic nrst;
	logic en;
	logic [`BP_PC_W-1:0] if_pc;
	logic [`BP_PC_W-1:0] id_pc;
	logic [`BP_PC_W-1:0] id_branch_target;
	logic id_is_jump;
	logic id_is_btype;
	logic [`BP_PC_W-1:0] exe_pc;
	logic exe_z;
	logic exe_less;
	logic [`BP_BTYPE_W-1:0] exe_btype;
	logic [`BP_CBTYPE_W-1:0] exe_c_btype;
	logic if_prediction;
	logic [1:0] exe_correction;
	logic flush;
	logic id_jump_in_bht;
	logic [`BP_PC_W-1:0] next_pc;

	step_t steps [$];
	string names [$];
	int n_checks = 0;
	int n_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;

	bp_top i_bp_top (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_pc(if_pc),
		.id_pc(id_pc),
		.id_branch_target(id_branch_target),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.exe_pc(exe_pc),
		.exe_z(exe_z),
		.exe_less(exe_less),
		.exe_btype(exe_btype),
		.exe_c_btype(exe_c_btype),
		.if_prediction(if_prediction),
		.exe_correction(exe_correction),
		.flush(flush),
		.id_jump_in_bht(id_jump_in_bht),
		.next_pc(next_pc)
	);

	// 8 ns clock
	always #4 CLK = ~CLK;

	////////////////////////////////////////////////////////////////////////////
	// run limit

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// table helpers

	task automatic add_step(
		input string name,
		input logic [2:0] ctl,
		input logic [`BP_PC_W-1:0] s_if_pc,
		input logic [`BP_PC_W-1:0] s_id_pc,
		input logic [`BP_PC_W-1:0] s_id_tgt,
		input logic [`BP_PC_W-1:0] s_exe_pc,
		input logic [1:0] flags,
		input logic [`BP_BTYPE_W-1:0] btype,
		input logic [`BP_CBTYPE_W-1:0] cbtype,
		input logic [2:0] exp_bits,
		input logic [1:0] exp_corr,
		input logic [`BP_PC_W-1:0] exp_next
	);
		step_t s;
		s.ctl = ctl;
		s.if_pc = s_if_pc;
		s.id_pc = s_id_pc;
		s.id_tgt = s_id_tgt;
		s.exe_pc = s_exe_pc;
		s.flags = flags;
		s.btype = btype;
		s.cbtype = cbtype;
		s.exp_bits = exp_bits;
		s.exp_corr = exp_corr;
		s.exp_next = exp_next;
		steps.push_back(s);
		names.push_back(name);
	endtask

	// columns: name, en/jump/btype, if_pc, id_pc, id target, exe_pc, z/less, btype,
	// then c_btype, expected pred/flush/jump_in_bht, correction, next_pc
	task automatic build_table();
		// allocation, branch starts weak not taken, jump starts strong taken
		add_step("idle", 3'b100, 11'h000, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h002);
		add_step("br alloc", 3'b101, 11'h013, 11'h013, 11'h080, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h015);
		add_step("br predict nt", 3'b100, 11'h013, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h015);
		// jump miss redirects to the decode target and flushes next cycle
		add_step("jump miss", 3'b110, 11'h027, 11'h025, 11'h100, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h100);
		add_step("jump miss flush", 3'b100, 11'h100, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h102);
		add_step("jump predict t", 3'b100, 11'h025, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b100, 2'b00, 11'h100);
		add_step("jump hit id", 3'b110, 11'h102, 11'h025, 11'h100, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b001, 2'b00, 11'h104);
		add_step("jump hit quiet", 3'b100, 11'h104, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h106);
		// beq taken trains up and saturates, then not taken trains down
		add_step("beq t mispredict", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h20,
			2'h0, 3'b010, 2'b11, 11'h080);
		add_step("beq t hold", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h20,
			2'h0, 3'b110, 2'b00, 11'h080);
		add_step("beq t sat", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h20,
			2'h0, 3'b100, 2'b00, 11'h080);
		add_step("beq t sat 2", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h20,
			2'h0, 3'b100, 2'b00, 11'h080);
		add_step("beq nt mispredict", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b00, 6'h20,
			2'h0, 3'b110, 2'b10, 11'h015);
		add_step("beq nt again", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b00, 6'h20,
			2'h0, 3'b110, 2'b10, 11'h015);
		add_step("br predict nt 2", 3'b100, 11'h013, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h015);
		// other branch types, and a mispredict during the owed flush cycle
		add_step("c.bnez nt", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h00,
			2'h1, 3'b000, 2'b00, 11'h015);
		add_step("blt t mispredict", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b01, 6'h08,
			2'h0, 3'b010, 2'b11, 11'h080);
		add_step("bgeu t no reload", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b00, 6'h01,
			2'h0, 3'b010, 2'b11, 11'h080);
		add_step("flush released", 3'b100, 11'h013, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b100, 2'b00, 11'h080);
		add_step("bge nt mispredict", 3'b100, 11'h013, 11'h000, 11'h000, 11'h013, 2'b01, 6'h04,
			2'h0, 3'b110, 2'b10, 11'h015);
		add_step("bge flush hold", 3'b100, 11'h013, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h015);
		// miss in EXE reads as not taken to address 0
		add_step("exe miss", 3'b100, 11'h033, 11'h000, 11'h000, 11'h033, 2'b10, 6'h20,
			2'h0, 3'b010, 2'b11, 11'h000);
		add_step("exe miss hold", 3'b100, 11'h033, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h035);
		// five jumps into set 9, the fifth replaces the first
		add_step("fifo alloc a", 3'b110, 11'h300, 11'h019, 11'h200, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h200);
		add_step("fifo alloc b", 3'b110, 11'h300, 11'h029, 11'h210, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h210);
		add_step("fifo alloc c", 3'b110, 11'h300, 11'h039, 11'h220, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h220);
		add_step("fifo alloc d", 3'b110, 11'h300, 11'h049, 11'h230, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h230);
		add_step("fifo probe a", 3'b100, 11'h019, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b100, 2'b00, 11'h200);
		add_step("fifo alloc e", 3'b110, 11'h300, 11'h059, 11'h240, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h240);
		add_step("fifo a evicted", 3'b100, 11'h019, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h01b);
		add_step("fifo b kept", 3'b100, 11'h029, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b100, 2'b00, 11'h210);
		add_step("fifo e present", 3'b100, 11'h059, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b100, 2'b00, 11'h240);
		// en low, no allocation, no training, flush state frozen
		add_step("en low jump", 3'b010, 11'h300, 11'h02a, 11'h111, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h111);
		add_step("en low no alloc", 3'b100, 11'h02a, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h02c);
		add_step("en low train", 3'b000, 11'h013, 11'h000, 11'h000, 11'h013, 2'b10, 6'h20,
			2'h0, 3'b010, 2'b11, 11'h080);
		add_step("en low no train", 3'b100, 11'h013, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h015);
		add_step("flush set", 3'b100, 11'h300, 11'h000, 11'h000, 11'h033, 2'b10, 6'h20,
			2'h0, 3'b010, 2'b11, 11'h000);
		add_step("en low held", 3'b000, 11'h300, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h302);
		add_step("en low held 2", 3'b000, 11'h300, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h302);
		add_step("flush last", 3'b100, 11'h300, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b010, 2'b00, 11'h302);
		add_step("flush clear", 3'b100, 11'h300, 11'h000, 11'h000, 11'h000, 2'b00, 6'h00,
			2'h0, 3'b000, 2'b00, 11'h302);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drive and compare

	task automatic apply_step(input step_t s);
		en = s.ctl[2];
		id_is_jump = s.ctl[1];
		id_is_btype = s.ctl[0];
		if_pc = s.if_pc;
		id_pc = s.id_pc;
		id_branch_target = s.id_tgt;
		exe_pc = s.exe_pc;
		exe_z = s.flags[1];
		exe_less = s.flags[0];
		exe_btype = s.btype;
		exe_c_btype = s.cbtype;
	endtask

	task automatic check_value(input string step, input string sig,
		input logic [31:0] expected, input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAIL %s %s: expected 0x%0h actual 0x%0h", step, sig, expected, actual);
		end
	endtask

	task automatic check_outputs(input int idx);
		step_t s;
		s = steps[idx];
		check_value(names[idx], "if_prediction", 32'(s.exp_bits[2]), 32'(if_prediction));
		check_value(names[idx], "flush", 32'(s.exp_bits[1]), 32'(flush));
		check_value(names[idx], "id_jump_in_bht", 32'(s.exp_bits[0]), 32'(id_jump_in_bht));
		check_value(names[idx], "exe_correction", 32'(s.exp_corr), 32'(exe_correction));
		check_value(names[idx], "next_pc", 32'(s.exp_next), 32'(next_pc));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		CLK = 1'b0;
		nrst = 1'b0;
		en = 1'b0;
		if_pc = '0;
		id_pc = '0;
		id_branch_target = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
		exe_c_btype = '0;
		build_table();
		cycle_limit = steps.size() + reset_cycles + timeout_slack;
		repeat (reset_cycles) @(posedge CLK);
		#1;
		nrst = 1'b1;
		// one row per cycle, drive 1 ns after the edge, sample before the next
		for (int i = 0; i < steps.size(); i++) begin
			@(posedge CLK);
			#1;
			apply_step(steps[i]);
			#5;
			check_outputs(i);
		end
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
